//--- mem_slot_pkg.sv
// The slot index is two bits wide so a queue of more than four slots is not supported
package mem_slot_pkg;

	// ========================================================================
	// Slot life cycle
	// ========================================================================

	// A slot leaves AVAIL when a request is written into it
	// and comes back to AVAIL one cycle after its bus cycle completes
	typedef enum logic [1:0] {
		SLOT_AVAIL  = 2'd0,
		SLOT_READY  = 2'd1,
		SLOT_ACTIVE = 2'd2,
		SLOT_DELAY  = 2'd3
	} mem_slot_state_t;

	// Index of one slot in the array
	typedef logic [1:0] slot_idx_t;

	// Tag handed in by the client and returned with the response
	typedef logic [3:0] mem_tag_t;

	// Number of slots when the top level does not override it
	localparam int SLOT_COUNT_DEF = 4;

endpackage

//--- mem_bus_pkg.sv
// Word addressed 32-bit memory bus with a two-bit configuration address space
package mem_bus_pkg;

	// ========================================================================
	// Memory bus types
	// ========================================================================

	// Word address driven on wb_adr_o
	typedef logic [31:0] mem_adr_t;

	// Read and write data on the bus and on the configuration port
	typedef logic [31:0] mem_dat_t;

	// Byte selects, every access here moves a whole word
	typedef logic [3:0] mem_sel_t;

	// ========================================================================
	// Configuration register map
	// ========================================================================

	// Bit 0 is issue enable and bits 7 to 4 are the slot enable mask
	localparam logic [1:0] REG_CTRL  = 2'd0;
	// Any write here cancels the requests still waiting in READY
	localparam logic [1:0] REG_FLUSH = 2'd1;
	// Sixteen-bit completion count that wraps around
	localparam logic [1:0] REG_COUNT = 2'd2;

endpackage

//--- mem_slot_if.sv
// Only one bus request is offered at a time and done is a single-cycle pulse
`timescale 1ns/1ps

interface mem_slot_if;

	// Lowest-numbered active slot as offered by the slot array
	logic                   req_valid;
	logic                   req_we;
	mem_bus_pkg::mem_adr_t  req_adr;
	mem_bus_pkg::mem_dat_t  req_dat;
	mem_slot_pkg::slot_idx_t req_slot;

	// Completion from the bus master, valid in the cycle of the acknowledge
	logic                   done;
	mem_slot_pkg::slot_idx_t done_slot;
	mem_bus_pkg::mem_dat_t  done_dat;

	// The slot array offers requests and takes completions
	modport slots (output req_valid, req_we, req_adr, req_dat, req_slot,
		input done, done_slot, done_dat);

	// The bus master takes requests and reports completions
	modport master (input req_valid, req_we, req_adr, req_dat, req_slot,
		output done, done_slot, done_dat);

endinterface

//--- mem_slot_state.sv
// The owner must raise set_ready_i only while the slot is available
`timescale 1ns/1ps

module mem_slot_state (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          ack_i,
	input  logic                          set_ready_i,
	input  logic                          set_avail_i,
	output mem_slot_pkg::mem_slot_state_t state_o
);
	import mem_slot_pkg::*;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_o <= SLOT_AVAIL;
		end else begin
			// Normal progress of the slot through its life cycle
			case (state_o)
				SLOT_AVAIL: ;
				SLOT_READY:
					// One cycle of settling before the slot may go on the bus
					state_o <= SLOT_ACTIVE;
				SLOT_ACTIVE:
					if (ack_i)
						state_o <= SLOT_DELAY;
				SLOT_DELAY:
					// The response is offered in this state for exactly one cycle
					state_o <= SLOT_AVAIL;
				default:
					state_o <= SLOT_AVAIL;
			endcase
			// A new request overrides the normal progress
			if (set_ready_i)
				state_o <= SLOT_READY;
			// Cancelling wins over everything else
			if (set_avail_i)
				state_o <= SLOT_AVAIL;
		end
	end

	// The array allocates only into free slots, so a live request is never overwritten
	a_ready_from_avail: assert property (@(posedge clk_i) disable iff (rst_i)
		set_ready_i |-> state_o == SLOT_AVAIL);

endmodule

//--- mem_slot_array.sv
// Responses are not back-pressured and the slot mask covers at most four slots
`timescale 1ns/1ps

module mem_slot_array #(
	parameter int SLOT_COUNT = mem_slot_pkg::SLOT_COUNT_DEF
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   req_valid_i,
	input  logic                   req_we_i,
	input  mem_bus_pkg::mem_adr_t  req_adr_i,
	input  mem_bus_pkg::mem_dat_t  req_dat_i,
	input  mem_slot_pkg::mem_tag_t req_tag_i,
	output logic                   req_ready_o,
	input  logic                   issue_en_i,
	input  logic                   flush_i,
	input  logic [SLOT_COUNT-1:0]  slot_mask_i,
	output logic                   resp_valid_o,
	output mem_slot_pkg::mem_tag_t resp_tag_o,
	output mem_bus_pkg::mem_dat_t  resp_dat_o,
	mem_slot_if.slots              bus
);
	import mem_slot_pkg::*;
	import mem_bus_pkg::*;

	// Per-slot request fields, written on allocation
	mem_slot_state_t slot_state [SLOT_COUNT];
	logic            slot_we    [SLOT_COUNT];
	mem_adr_t        slot_adr   [SLOT_COUNT];
	mem_dat_t        slot_dat   [SLOT_COUNT];
	mem_tag_t        slot_tag   [SLOT_COUNT];

	// Decoded views of the slot states
	logic [SLOT_COUNT-1:0] avail_vec;
	logic [SLOT_COUNT-1:0] active_vec;
	logic [SLOT_COUNT-1:0] delay_vec;
	logic [SLOT_COUNT-1:0] set_ready;
	logic [SLOT_COUNT-1:0] set_avail;
	logic [SLOT_COUNT-1:0] slot_ack;
	slot_idx_t             alloc_idx;
	slot_idx_t             active_idx;
	slot_idx_t             delay_idx;
	logic                  req_fire;

	// Index of the lowest set bit, zero when none is set
	function automatic slot_idx_t lowest_set(input logic [SLOT_COUNT-1:0] vec);
		slot_idx_t idx;
		idx = '0;
		for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
			if (vec[i])
				idx = slot_idx_t'(i);
		end
		return idx;
	endfunction

	// ========================================================================
	// Slot state machines
	// ========================================================================

	always_comb begin
		for (int i = 0; i < SLOT_COUNT; i++) begin
			// Masked slots are never handed out but finish what they hold
			avail_vec[i]  = slot_state[i] == SLOT_AVAIL && slot_mask_i[i];
			active_vec[i] = slot_state[i] == SLOT_ACTIVE;
			delay_vec[i]  = slot_state[i] == SLOT_DELAY;
			// Flush only reaches requests that have not been offered to the bus
			set_avail[i]  = flush_i && slot_state[i] == SLOT_READY;
			slot_ack[i]   = bus.done && bus.done_slot == slot_idx_t'(i);
		end
	end

	assign alloc_idx   = lowest_set(avail_vec);
	assign active_idx  = lowest_set(active_vec);
	assign delay_idx   = lowest_set(delay_vec);
	assign req_ready_o = issue_en_i && |avail_vec;
	assign req_fire    = req_valid_i && req_ready_o;

	always_comb begin
		for (int i = 0; i < SLOT_COUNT; i++)
			set_ready[i] = req_fire && alloc_idx == slot_idx_t'(i);
	end

	for (genvar g = 0; g < SLOT_COUNT; g++) begin : g_slot
		mem_slot_state u_state (
			.clk_i       (clk_i),
			.rst_i       (rst_i),
			.ack_i       (slot_ack[g]),
			.set_ready_i (set_ready[g]),
			.set_avail_i (set_avail[g]),
			.state_o     (slot_state[g])
		);
	end

	// ========================================================================
	// Slot fields, bus offer and response
	// ========================================================================

	always_ff @(posedge clk_i) begin
		if (req_fire) begin
			slot_we[alloc_idx]  <= req_we_i;
			slot_adr[alloc_idx] <= req_adr_i;
			slot_dat[alloc_idx] <= req_dat_i;
			slot_tag[alloc_idx] <= req_tag_i;
		end
		// The completed slot is active, so it never collides with the allocation
		if (bus.done)
			slot_dat[bus.done_slot] <= slot_we[bus.done_slot] ? '0 : bus.done_dat;
	end

	// Active slots wait while issue is disabled
	assign bus.req_valid = issue_en_i && |active_vec;
	assign bus.req_we    = slot_we[active_idx];
	assign bus.req_adr   = slot_adr[active_idx];
	assign bus.req_dat   = slot_dat[active_idx];
	assign bus.req_slot  = active_idx;

	assign resp_valid_o = |delay_vec;
	assign resp_tag_o   = slot_tag[delay_idx];
	assign resp_dat_o   = slot_dat[delay_idx];

	// One bus cycle at a time means one response at a time
	a_one_delay: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0(delay_vec));

	// The master only ever completes a slot that is on the bus
	a_done_active: assert property (@(posedge clk_i) disable iff (rst_i)
		bus.done |-> slot_state[bus.done_slot] == SLOT_ACTIVE);

endmodule

//--- mem_bus_master.sv
// Wishbone classic single cycles only with no error or retry and full-word selects
`timescale 1ns/1ps

module mem_bus_master (
	input  logic                  clk_i,
	input  logic                  rst_i,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output mem_bus_pkg::mem_adr_t wb_adr_o,
	output mem_bus_pkg::mem_dat_t wb_dat_o,
	output mem_bus_pkg::mem_sel_t wb_sel_o,
	input  mem_bus_pkg::mem_dat_t wb_dat_i,
	input  logic                  wb_ack_i,
	mem_slot_if.master            bus
);
	import mem_slot_pkg::*;

	typedef enum logic {
		MST_IDLE = 1'b0,
		MST_BUSY = 1'b1
	} mst_state_t;

	mst_state_t state_q;
	// Slot served by the cycle now on the bus
	slot_idx_t  slot_q;

	// ========================================================================
	// Cycle control
	// ========================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= MST_IDLE;
		end else begin
			case (state_q)
				MST_IDLE:
					if (bus.req_valid)
						state_q <= MST_BUSY;
				MST_BUSY:
					// Both strobes fall on the edge that samples the acknowledge
					if (wb_ack_i)
						state_q <= MST_IDLE;
				default:
					state_q <= MST_IDLE;
			endcase
		end
	end

	// Address, data and direction are loaded once and held for the whole cycle
	always_ff @(posedge clk_i) begin
		if (state_q == MST_IDLE && bus.req_valid) begin
			wb_we_o  <= bus.req_we;
			wb_adr_o <= bus.req_adr;
			wb_dat_o <= bus.req_dat;
			slot_q   <= bus.req_slot;
		end
	end

	assign wb_cyc_o = state_q == MST_BUSY;
	assign wb_stb_o = state_q == MST_BUSY;
	assign wb_sel_o = '1;

	// Completion goes back in the acknowledge cycle itself
	assign bus.done      = wb_cyc_o && wb_ack_i;
	assign bus.done_slot = slot_q;
	assign bus.done_dat  = wb_dat_i;

	// The slave only acknowledges a cycle that is running
	a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_ack_i |-> wb_cyc_o && wb_stb_o);

	// A cycle without acknowledge carries on unchanged into the next clock
	a_cycle_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_cyc_o && !wb_ack_i |=> wb_cyc_o && wb_stb_o && $stable(wb_adr_o)
			&& $stable(wb_we_o) && $stable(wb_dat_o));

endmodule

//--- mem_ctrl_regs.sv
// Single-cycle register port with no wait states and no write strobe per byte
`timescale 1ns/1ps

module mem_ctrl_regs (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  cfg_we_i,
	input  logic [1:0]            cfg_adr_i,
	input  mem_bus_pkg::mem_dat_t cfg_dat_i,
	output mem_bus_pkg::mem_dat_t cfg_dat_o,
	input  logic                  resp_valid_i,
	output logic                  issue_en_o,
	output logic                  flush_o,
	output logic [3:0]            slot_mask_o
);
	import mem_bus_pkg::*;

	logic        issue_en_q;
	logic [3:0]  slot_mask_q;
	logic        flush_q;
	// Completion counter, wraps at sixteen bits
	logic [15:0] count_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			issue_en_q  <= 1'b0;
			slot_mask_q <= '0;
			flush_q     <= 1'b0;
			count_q     <= '0;
		end else begin
			// The written value is ignored, the write itself is the command
			flush_q <= cfg_we_i && cfg_adr_i == REG_FLUSH;
			if (cfg_we_i && cfg_adr_i == REG_CTRL) begin
				issue_en_q  <= cfg_dat_i[0];
				slot_mask_q <= cfg_dat_i[7:4];
			end
			if (resp_valid_i)
				count_q <= count_q + 16'd1;
		end
	end

	// Read data follows the address within the same cycle
	always_comb begin
		cfg_dat_o = '0;
		case (cfg_adr_i)
			REG_CTRL: begin
				cfg_dat_o[0]   = issue_en_q;
				cfg_dat_o[7:4] = slot_mask_q;
			end
			REG_COUNT:
				cfg_dat_o[15:0] = count_q;
			default: ;
		endcase
	end

	assign issue_en_o  = issue_en_q;
	assign flush_o     = flush_q;
	assign slot_mask_o = slot_mask_q;

endmodule

//--- mem_queue_top.sv
// SLOT_COUNT must lie between two and four and responses must be taken when offered
`timescale 1ns/1ps

module mem_queue_top #(
	parameter int SLOT_COUNT = mem_slot_pkg::SLOT_COUNT_DEF
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	// Client request port
	input  logic                   req_valid_i,
	input  logic                   req_we_i,
	input  mem_bus_pkg::mem_adr_t  req_adr_i,
	input  mem_bus_pkg::mem_dat_t  req_dat_i,
	input  mem_slot_pkg::mem_tag_t req_tag_i,
	output logic                   req_ready_o,
	// Tagged responses
	output logic                   resp_valid_o,
	output mem_slot_pkg::mem_tag_t resp_tag_o,
	output mem_bus_pkg::mem_dat_t  resp_dat_o,
	// Wishbone classic master
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic                   wb_we_o,
	output mem_bus_pkg::mem_adr_t  wb_adr_o,
	output mem_bus_pkg::mem_dat_t  wb_dat_o,
	output mem_bus_pkg::mem_sel_t  wb_sel_o,
	input  mem_bus_pkg::mem_dat_t  wb_dat_i,
	input  logic                   wb_ack_i,
	// Configuration register port
	input  logic                   cfg_we_i,
	input  logic [1:0]             cfg_adr_i,
	input  mem_bus_pkg::mem_dat_t  cfg_dat_i,
	output mem_bus_pkg::mem_dat_t  cfg_dat_o
);

	logic       issue_en;
	logic       flush;
	logic [3:0] slot_mask;

	// Slot array to bus master hand-off
	mem_slot_if slot_bus ();

	// The slot index and the mask register both stop at four slots
	if (SLOT_COUNT < 2 || SLOT_COUNT > 4) begin : g_bad_count
		$error("SLOT_COUNT %0d is outside the range 2 to 4", SLOT_COUNT);
	end

	mem_slot_array #(
		.SLOT_COUNT (SLOT_COUNT)
	) u_slot_array (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_valid_i  (req_valid_i),
		.req_we_i     (req_we_i),
		.req_adr_i    (req_adr_i),
		.req_dat_i    (req_dat_i),
		.req_tag_i    (req_tag_i),
		.req_ready_o  (req_ready_o),
		.issue_en_i   (issue_en),
		.flush_i      (flush),
		.slot_mask_i  (slot_mask[SLOT_COUNT-1:0]),
		.resp_valid_o (resp_valid_o),
		.resp_tag_o   (resp_tag_o),
		.resp_dat_o   (resp_dat_o),
		.bus          (slot_bus.slots)
	);

	mem_bus_master u_bus_master (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_we_o  (wb_we_o),
		.wb_adr_o (wb_adr_o),
		.wb_dat_o (wb_dat_o),
		.wb_sel_o (wb_sel_o),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i),
		.bus      (slot_bus.master)
	);

	// Completions are counted from the response strobe
	mem_ctrl_regs u_ctrl_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cfg_we_i     (cfg_we_i),
		.cfg_adr_i    (cfg_adr_i),
		.cfg_dat_i    (cfg_dat_i),
		.cfg_dat_o    (cfg_dat_o),
		.resp_valid_i (resp_valid_o),
		.issue_en_o   (issue_en),
		.flush_o      (flush),
		.slot_mask_o  (slot_mask)
	);

endmodule

//--- tb_mem_queue.sv
// Expects the default four slots and carries each request's tag in the low nibble of its address
`timescale 1ns/1ps

module tb_mem_queue;
	import mem_slot_pkg::*;
	import mem_bus_pkg::*;

	localparam int          REQ_TOTAL = 29;
	localparam mem_dat_t    RD_MASK   = 32'h5a5a_0000;
	localparam logic [31:0] SEED      = 32'h014b_e73e;
	// Which one-cycle check the stimulus asks for
	localparam int CHK_NONE  = 0;
	localparam int CHK_IDLE  = 1;
	localparam int CHK_READY = 2;
	localparam int CHK_FILL  = 3;
	localparam int CHK_COUNT = 4;

	logic       clk_i;
	logic       rst_i;
	logic       req_valid_i;
	logic       req_we_i;
	mem_adr_t   req_adr_i;
	mem_dat_t   req_dat_i;
	mem_tag_t   req_tag_i;
	logic       req_ready_o;
	logic       resp_valid_o;
	mem_tag_t   resp_tag_o;
	mem_dat_t   resp_dat_o;
	logic       wb_cyc_o;
	logic       wb_stb_o;
	logic       wb_we_o;
	mem_adr_t   wb_adr_o;
	mem_dat_t   wb_dat_o;
	mem_sel_t   wb_sel_o;
	mem_dat_t   wb_dat_i;
	logic       wb_ack_i;
	logic       cfg_we_i;
	logic [1:0] cfg_adr_i;
	mem_dat_t   cfg_dat_i;
	mem_dat_t   cfg_dat_o;

	// Scoreboard keyed by tag
	logic [15:0] pending;
	logic [15:0] on_bus;
	logic        exp_we   [16];
	mem_adr_t    exp_adr  [16];
	mem_dat_t    exp_wdat [16];
	mem_dat_t    exp_dat  [16];
	mem_tag_t    next_tag;
	logic [31:0] stim_lfsr;
	logic [31:0] wait_lfsr;
	logic        ack_hold;
	logic        in_cycle;
	int          wait_left;
	int          check_sel;
	int          accepted;
	int          fill_expect;
	int          resp_seen;
	int          wr_cnt;
	int          err_cnt;
	int          err_mark;
	int          test_cnt;
	string       test_name;

	mem_queue_top #(
		.SLOT_COUNT (SLOT_COUNT_DEF)
	) mem_queue_top_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit returned
	function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = state[31] ^ state[21] ^ state[1] ^ state[0];
			state = {state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	task automatic show_mismatch(input logic [31:0] exp_v, input logic [31:0] act_v);
		err_cnt++;
		$display("Fail %s: expected %h, actual %h", test_name, exp_v, act_v);
	endtask

	// ========================================================================
	// Wishbone memory model and response monitor
	// ========================================================================

	// Acknowledges after 0 to 3 wait cycles unless the bus is being held
	// The data lines carry the address pattern in every cycle, stores included
	always @(posedge clk_i) begin
		#1;
		wb_ack_i = 1'b0;
		if (wb_cyc_o && !ack_hold) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				wait_left = rand_bits(wait_lfsr, 2);
			end
			if (wait_left == 0) begin
				wb_ack_i = 1'b1;
				wb_dat_i = wb_adr_o ^ RD_MASK;
				in_cycle = 1'b0;
				if (wb_we_o)
					wr_cnt++;
			end else begin
				wait_left--;
			end
		end
	end

	always @(posedge clk_i) begin
		if (!rst_i && resp_valid_o) begin
			pending[resp_tag_o] <= 1'b0;
			resp_seen <= resp_seen + 1;
		end
		if (!rst_i && wb_cyc_o && wb_ack_i)
			on_bus[wb_adr_o[3:0]] <= 1'b1;
	end

	// ========================================================================
	// Checks
	// ========================================================================

	a_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		check_sel == CHK_IDLE |-> !req_ready_o && !wb_cyc_o)
		else flag_error("req_ready_o or wb_cyc_o went high while issue was disabled");

	a_ready_on: assert property (@(posedge clk_i) disable iff (rst_i)
		check_sel == CHK_READY |-> req_ready_o)
		else flag_error("req_ready_o stayed low after issue and all slots were enabled");

	// Strobe follows the cycle and every access moves a whole word
	a_bus_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_stb_o == wb_cyc_o && (!wb_cyc_o || wb_sel_o == 4'hf))
		else flag_error("wb_stb_o differed from wb_cyc_o or wb_sel_o was not all ones");

	// Covers responses for cancelled tags and second responses for the same tag
	a_resp_known: assert property (@(posedge clk_i) disable iff (rst_i)
		resp_valid_o |-> pending[resp_tag_o] && on_bus[resp_tag_o])
		else flag_error($sformatf("Response for tag %0d that no request is waiting for",
			$sampled(resp_tag_o)));

	a_resp_data: assert property (@(posedge clk_i) disable iff (rst_i)
		resp_valid_o |-> resp_dat_o == exp_dat[resp_tag_o])
		else show_mismatch(exp_dat[$sampled(resp_tag_o)], $sampled(resp_dat_o));

	a_bus_known: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_cyc_o && wb_ack_i |-> pending[wb_adr_o[3:0]] && !on_bus[wb_adr_o[3:0]]
			&& wb_adr_o == exp_adr[wb_adr_o[3:0]])
		else flag_error($sformatf("Bus cycle at address %h belongs to no waiting request",
			$sampled(wb_adr_o)));

	a_bus_dir: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_cyc_o && wb_ack_i |-> wb_we_o == exp_we[wb_adr_o[3:0]])
		else show_mismatch(exp_we[$sampled(wb_adr_o[3:0])], $sampled(wb_we_o));

	a_store_data: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_cyc_o && wb_ack_i && wb_we_o |-> wb_dat_o == exp_wdat[wb_adr_o[3:0]])
		else show_mismatch(exp_wdat[$sampled(wb_adr_o[3:0])], $sampled(wb_dat_o));

	a_fill: assert property (@(posedge clk_i) disable iff (rst_i)
		check_sel == CHK_FILL |-> accepted == fill_expect)
		else show_mismatch(fill_expect, accepted);

	a_count: assert property (@(posedge clk_i) disable iff (rst_i)
		check_sel == CHK_COUNT |-> cfg_dat_o[15:0] == resp_seen[15:0])
		else show_mismatch(resp_seen[15:0], $sampled(cfg_dat_o[15:0]));

	// ========================================================================
	// Stimulus tasks that start and end 1 ns after a rising edge
	// ========================================================================

	// Offers one request for one cycle and reports whether it transferred
	task automatic offer_req(input logic we, input logic with_flush, output logic taken_o);
		logic [31:0] rnd;
		mem_adr_t    adr;
		mem_dat_t    dat;
		rnd = rand_bits(stim_lfsr, 28);
		adr = {rnd[27:0], next_tag};
		dat = rand_bits(stim_lfsr, 32);
		req_valid_i = 1'b1;
		req_we_i = we;
		req_adr_i = adr;
		req_dat_i = dat;
		req_tag_i = next_tag;
		if (with_flush) begin
			cfg_we_i = 1'b1;
			cfg_adr_i = REG_FLUSH;
		end
		// Ready only moves on a clock edge, so its value now decides the transfer
		taken_o = req_ready_o;
		if (taken_o) begin
			exp_we[next_tag] = we;
			exp_adr[next_tag] = adr;
			exp_wdat[next_tag] = dat;
			exp_dat[next_tag] = we ? '0 : adr ^ RD_MASK;
			on_bus[next_tag] <= 1'b0;
			// A request flushed in its READY cycle must never answer
			pending[next_tag] <= !with_flush;
			next_tag = next_tag + 1'b1;
			accepted++;
		end
		@(posedge clk_i);
		#1;
		req_valid_i = 1'b0;
		cfg_we_i = 1'b0;
	endtask

	task automatic send_req(input logic we);
		logic taken;
		taken = 1'b0;
		while (!taken)
			offer_req(we, 1'b0, taken);
	endtask

	task automatic cfg_write(input logic [1:0] adr, input mem_dat_t dat);
		cfg_we_i = 1'b1;
		cfg_adr_i = adr;
		cfg_dat_i = dat;
		@(posedge clk_i);
		#1;
		cfg_we_i = 1'b0;
	endtask

	task automatic run_check(input int sel);
		check_sel = sel;
		@(posedge clk_i);
		#1;
		check_sel = CHK_NONE;
	endtask

	// Holds the bus and offers loads until ready has stayed low for eight cycles
	task automatic fill_slots(input int expect_n);
		logic taken;
		int   idle;
		accepted = 0;
		idle = 0;
		ack_hold = 1'b1;
		while (idle < 8) begin
			offer_req(1'b0, 1'b0, taken);
			idle = taken ? 0 : idle + 1;
		end
		fill_expect = expect_n;
		run_check(CHK_FILL);
	endtask

	task automatic drain_queue();
		ack_hold = 1'b0;
		while (pending != '0) begin
			@(posedge clk_i);
			#1;
		end
		repeat (2) @(posedge clk_i);
		#1;
	endtask

	task automatic end_test();
		$display("%s finished with %0d errors", test_name, err_cnt - err_mark);
		err_mark = err_cnt;
		test_cnt++;
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin : watchdog
		repeat (16 + 200 * REQ_TOTAL) @(posedge clk_i);
		$display("Watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		logic taken;
		rst_i = 1'b1;
		req_valid_i = 1'b0;
		req_we_i = 1'b0;
		req_adr_i = '0;
		req_dat_i = '0;
		req_tag_i = '0;
		wb_dat_i = '0;
		wb_ack_i = 1'b0;
		cfg_we_i = 1'b0;
		cfg_adr_i = REG_CTRL;
		cfg_dat_i = '0;
		pending = '0;
		on_bus = '0;
		next_tag = '0;
		stim_lfsr = SEED;
		wait_lfsr = SEED;
		ack_hold = 1'b0;
		in_cycle = 1'b0;
		wait_left = 0;
		check_sel = CHK_NONE;
		accepted = 0;
		fill_expect = 0;
		resp_seen = 0;
		wr_cnt = 0;
		err_cnt = 0;
		err_mark = 0;
		test_cnt = 0;
		repeat (16) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		// A pending request must not get through while issue is off
		test_name = "issue enable";
		req_valid_i = 1'b1;
		check_sel = CHK_IDLE;
		repeat (8) @(posedge clk_i);
		#1;
		check_sel = CHK_NONE;
		req_valid_i = 1'b0;
		cfg_write(REG_CTRL, 32'h0000_00f1);
		run_check(CHK_READY);
		end_test();

		test_name = "load responses";
		for (int i = 0; i < 12; i++) begin
			send_req(1'b0);
			if (rand_bits(stim_lfsr, 1) != 0) begin
				@(posedge clk_i);
				#1;
			end
		end
		drain_queue();
		end_test();

		test_name = "store cycles";
		for (int i = 0; i < 8; i++)
			send_req(1'b1);
		drain_queue();
		end_test();

		// First all four slots and then only slots 0 and 1
		test_name = "slot fill";
		fill_slots(4);
		drain_queue();
		cfg_write(REG_CTRL, 32'h0000_0031);
		fill_slots(2);
		drain_queue();
		cfg_write(REG_CTRL, 32'h0000_00f1);
		end_test();

		// The flush write lands in the same cycle as the request it cancels
		test_name = "flush";
		ack_hold = 1'b1;
		send_req(1'b0);
		while (!wb_cyc_o) begin
			@(posedge clk_i);
			#1;
		end
		offer_req(1'b0, 1'b1, taken);
		offer_req(1'b0, 1'b1, taken);
		repeat (4) @(posedge clk_i);
		#1;
		drain_queue();
		repeat (32) @(posedge clk_i);
		#1;
		end_test();

		test_name = "completion count";
		cfg_adr_i = REG_COUNT;
		run_check(CHK_COUNT);
		end_test();

		$display("%0d tests, %0d responses, %0d writes, %0d errors",
			test_cnt, resp_seen, wr_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- list.f
mem_slot_pkg.sv
mem_bus_pkg.sv
mem_slot_if.sv
mem_slot_state.sv
mem_slot_array.sv
mem_bus_master.sv
mem_ctrl_regs.sv
mem_queue_top.sv
tb_mem_queue.sv
